//--- logic/hawk_params.svh
// widths, memory map and free-list sizing for the page-guard manager
// include in any file that needs a width or a base address
`ifndef HAWK_PARAMS_SVH
`define HAWK_PARAMS_SVH

// axi read port, one 64-byte cache line per beat
`define HAWK_AXI_DATA_WIDTH 512
`define HAWK_AXI_ADDR_WIDTH 48
`define HAWK_AXI_RESP_WIDTH 2

// physical page address held in att and free-list slots
`define HAWK_PPA_WIDTH 36

// start of the host page region, hppa below this is illegal
`define HAWK_HPPA_BASE 48'h0001_0000_0000

// att lines, eight 64-bit slots per line
`define HAWK_ATT_START 48'h0000_4000_0000

// free-list lines, four 128-bit slots per line
`define HAWK_LIST_START 48'h0000_8000_0000

// free-list ring
// pointer width must cover LST_ENTRY_MAX slots
`define HAWK_LST_ENTRY_MAX 64
`define HAWK_LST_PTR_WIDTH 6

`endif

//--- logic/hawk_pkg.sv
// shared packet types and state encodings for the page-guard manager
// referenced by scoped name from the RTL and the testbench
`include "hawk_params.svh"

package hawk_pkg;

	// lookup strobe from the requester
	typedef struct packed {
		logic                            lookup;
		logic [`HAWK_AXI_ADDR_WIDTH-1:0] hppa;
	} att_lkup_reqpkt_t;

	// read address channel plus rready, driven by the manager
	typedef struct packed {
		logic                            arvalid;
		logic [`HAWK_AXI_ADDR_WIDTH-1:0] addr;
		logic                            rready;
	} axi_rd_reqpkt_t;

	// memory side ready
	typedef struct packed {
		logic arready;
	} axi_rd_rdypkt_t;

	// read data channel, single beat
	typedef struct packed {
		logic                            rvalid;
		logic                            rlast;
		logic [`HAWK_AXI_RESP_WIDTH-1:0] rresp;
		logic [`HAWK_AXI_DATA_WIDTH-1:0] rdata;
	} axi_rd_resppkt_t;

	// page state kept in an att slot
	typedef enum logic [1:0] {
		sts_uncomp = 2'd0,
		sts_dalloc = 2'd1,
		sts_comp   = 2'd2
	} att_sts_t;

	// one 64-bit att slot, ppa in the low bits
	typedef struct packed {
		logic                       valid;
		att_sts_t                   sts;
		logic [24:0]                rsvd;
		logic [`HAWK_PPA_WIDTH-1:0] ppa;
	} att_entry_t;

	// one 128-bit free-list slot
	typedef struct packed {
		logic [91:0]                rsvd;
		logic [`HAWK_PPA_WIDTH-1:0] ppa;
	} lst_entry_t;

	typedef struct packed {
		logic [`HAWK_LST_PTR_WIDTH-1:0] head;
		logic [`HAWK_LST_PTR_WIDTH-1:0] tail;
	} free_lst_ptrs_t;

	// translation result, strobes are one cycle wide
	typedef struct packed {
		logic                            allow_access;
		logic                            tbl_update;
		logic                            comp_pending;
		logic                            no_free;
		logic                            att_hit;
		att_sts_t                        sts;
		logic [`HAWK_PPA_WIDTH-1:0]      ppa;
		logic [`HAWK_AXI_ADDR_WIDTH-1:0] hppa;
	} trnsl_reqpkt_t;

	typedef enum logic [3:0] {
		idle             = 4'd0,
		lookup_att       = 4'd1,
		wait_att_entry   = 4'd2,
		decode_att_entry = 4'd3,
		pop_free_lst     = 4'd4,
		wait_lst_entry   = 4'd5,
		allocate_ppa     = 4'd6,
		bus_error        = 4'd7
	} pgrd_state_t;

endpackage

//--- logic/hawk_free_lst_ptrs.sv
// head and tail of the free-page ring kept in memory
// pop advances head, push advances tail, both wrap at the slot count
`timescale 1ns/1ps
`include "hawk_params.svh"

module hawk_free_lst_ptrs (
	input  logic                     clk_i,
	input  logic                     rst_ni,
	input  logic                     lst_pop,
	input  logic                     free_push,
	output hawk_pkg::free_lst_ptrs_t lst_ptrs,
	output logic                     lst_empty
);

	logic [`HAWK_LST_PTR_WIDTH-1:0] head_q;
	logic [`HAWK_LST_PTR_WIDTH-1:0] tail_q;
	logic [`HAWK_LST_PTR_WIDTH-1:0] head_nxt;
	logic [`HAWK_LST_PTR_WIDTH-1:0] tail_nxt;
	logic                           lst_full;

	// next slot in the ring
	function automatic logic [`HAWK_LST_PTR_WIDTH-1:0] ptr_inc(
		input logic [`HAWK_LST_PTR_WIDTH-1:0] ptr
	);
		if (ptr == `HAWK_LST_PTR_WIDTH'(`HAWK_LST_ENTRY_MAX - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign head_nxt = ptr_inc(head_q);
	assign tail_nxt = ptr_inc(tail_q);

	// list starts empty, pushes must come first
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			head_q <= '0;
			tail_q <= '0;
		end else begin
			if (lst_pop) begin
				head_q <= head_nxt;
			end
			if (free_push) begin
				tail_q <= tail_nxt;
			end
		end
	end

	assign lst_empty     = (head_q == tail_q);
	// one slot stays unused so full and empty differ
	assign lst_full      = (tail_nxt == head_q);
	assign lst_ptrs.head = head_q;
	assign lst_ptrs.tail = tail_q;

	// manager only pops after seeing lst_empty low
	a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
		lst_pop |-> !lst_empty);

	a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
		free_push |-> !lst_full);

endmodule

//--- logic/hawk_pgrd_mngr.sv
// page-guard lookup FSM that reads the att line of a host page and decodes its slot
// grants access on an uncompressed hit and pops a free page on a miss
`timescale 1ns/1ps
`include "hawk_params.svh"

module hawk_pgrd_mngr (
	input  logic                       clk_i,
	input  logic                       rst_ni,
	input  hawk_pkg::att_lkup_reqpkt_t lkup_reqpkt,
	input  hawk_pkg::free_lst_ptrs_t   lst_ptrs,
	input  logic                       lst_empty,
	input  hawk_pkg::axi_rd_rdypkt_t   rd_rdypkt,
	input  hawk_pkg::axi_rd_resppkt_t  rd_resppkt,
	output hawk_pkg::axi_rd_reqpkt_t   rd_reqpkt,
	output hawk_pkg::trnsl_reqpkt_t    trnsl_reqpkt,
	output logic                       lst_pop,
	output logic                       pgrd_mngr_ready,
	output logic                       bus_error
);

	hawk_pkg::pgrd_state_t state_q;
	hawk_pkg::pgrd_state_t state_d;
	logic [`HAWK_AXI_ADDR_WIDTH-1:0] hppa_q;
	logic [`HAWK_AXI_ADDR_WIDTH-1:0] hppa_d;
	logic [`HAWK_AXI_ADDR_WIDTH-1:0] addr_q;
	logic [`HAWK_AXI_ADDR_WIDTH-1:0] addr_d;
	logic                            arvalid_q;
	logic                            arvalid_d;
	logic                            rready_q;
	logic [`HAWK_AXI_DATA_WIDTH-1:0] line_q;
	logic [`HAWK_AXI_DATA_WIDTH-1:0] line_d;
	hawk_pkg::trnsl_reqpkt_t         trnsl_q;
	hawk_pkg::trnsl_reqpkt_t         trnsl_d;
	hawk_pkg::att_entry_t            att_entry;
	hawk_pkg::lst_entry_t            lst_entry;
	logic                            rsp_done;
	logic                            rsp_err;
	logic                            result_pulse;

	// att line holding this page with 8 slots of 8 bytes per 64-byte line
	function automatic logic [`HAWK_AXI_ADDR_WIDTH-1:0] att_line_addr(
		input logic [`HAWK_AXI_ADDR_WIDTH-1:0] hppa
	);
		logic [`HAWK_AXI_ADDR_WIDTH-1:0] offs;
		offs = hppa - `HAWK_HPPA_BASE;
		return `HAWK_ATT_START + ((offs >> 3) << 6);
	endfunction

	// free-list line holding the head slot with 4 slots per line
	function automatic logic [`HAWK_AXI_ADDR_WIDTH-1:0] lst_line_addr(
		input logic [`HAWK_LST_PTR_WIDTH-1:0] head
	);
		return `HAWK_LIST_START + (`HAWK_AXI_ADDR_WIDTH'(head >> 2) << 6);
	endfunction

	function automatic hawk_pkg::att_entry_t att_slot(
		input logic [`HAWK_AXI_DATA_WIDTH-1:0] line,
		input logic [`HAWK_AXI_ADDR_WIDTH-1:0] hppa
	);
		logic [`HAWK_AXI_ADDR_WIDTH-1:0] offs;
		offs = hppa - `HAWK_HPPA_BASE;
		return line[offs[2:0]*64 +: 64];
	endfunction

	function automatic hawk_pkg::lst_entry_t lst_slot(
		input logic [`HAWK_AXI_DATA_WIDTH-1:0] line,
		input logic [`HAWK_LST_PTR_WIDTH-1:0]  head
	);
		return line[head[1:0]*128 +: 128];
	endfunction

	// only single-beat reads are issued so rvalid with rlast ends a read
	assign rsp_done  = rd_resppkt.rvalid && rd_resppkt.rlast;
	assign rsp_err   = (rd_resppkt.rresp != '0);
	assign att_entry = att_slot(line_q, hppa_q);
	// head holds still between decode and allocate since only push moves tail
	assign lst_entry = lst_slot(line_q, lst_ptrs.head);

	always_comb begin
		state_d   = state_q;
		hppa_d    = hppa_q;
		addr_d    = addr_q;
		line_d    = line_q;
		arvalid_d = 1'b0;
		trnsl_d   = '0;
		case (state_q)
			hawk_pkg::idle: begin
				if (lkup_reqpkt.lookup && pgrd_mngr_ready) begin
					hppa_d  = lkup_reqpkt.hppa;
					state_d = hawk_pkg::lookup_att;
				end
			end
			hawk_pkg::lookup_att: begin
				// arready low is the only back-pressure
				if (rd_rdypkt.arready && !arvalid_q) begin
					addr_d    = att_line_addr(hppa_q);
					arvalid_d = 1'b1;
					state_d   = hawk_pkg::wait_att_entry;
				end
			end
			hawk_pkg::wait_att_entry: begin
				if (rsp_done) begin
					if (rsp_err) begin
						state_d = hawk_pkg::bus_error;
					end else begin
						line_d  = rd_resppkt.rdata;
						state_d = hawk_pkg::decode_att_entry;
					end
				end
			end
			hawk_pkg::decode_att_entry: begin
				state_d = hawk_pkg::idle;
				if (att_entry.valid) begin
					case (att_entry.sts)
						hawk_pkg::sts_uncomp: begin
							trnsl_d.allow_access = 1'b1;
							trnsl_d.att_hit      = 1'b1;
							trnsl_d.sts          = att_entry.sts;
							trnsl_d.ppa          = att_entry.ppa;
							trnsl_d.hppa         = hppa_q;
						end
						hawk_pkg::sts_comp: begin
							// decompression not handled so flag it and drop back
							trnsl_d.comp_pending = 1'b1;
							trnsl_d.att_hit      = 1'b1;
							trnsl_d.sts          = att_entry.sts;
							trnsl_d.ppa          = att_entry.ppa;
							trnsl_d.hppa         = hppa_q;
						end
						// dalloc and the unused code give no result
						default: begin
							trnsl_d = '0;
						end
					endcase
				end else if (lst_empty) begin
					// no victim search so report and give up
					trnsl_d.no_free = 1'b1;
					trnsl_d.hppa    = hppa_q;
				end else begin
					state_d = hawk_pkg::pop_free_lst;
				end
			end
			hawk_pkg::pop_free_lst: begin
				if (rd_rdypkt.arready && !arvalid_q) begin
					addr_d    = lst_line_addr(lst_ptrs.head);
					arvalid_d = 1'b1;
					state_d   = hawk_pkg::wait_lst_entry;
				end
			end
			hawk_pkg::wait_lst_entry: begin
				if (rsp_done) begin
					if (rsp_err) begin
						state_d = hawk_pkg::bus_error;
					end else begin
						line_d  = rd_resppkt.rdata;
						state_d = hawk_pkg::allocate_ppa;
					end
				end
			end
			hawk_pkg::allocate_ppa: begin
				// new mapping goes in uncompressed and the same strobe pops the list
				trnsl_d.tbl_update = 1'b1;
				trnsl_d.sts        = hawk_pkg::sts_uncomp;
				trnsl_d.ppa        = lst_entry.ppa;
				trnsl_d.hppa       = hppa_q;
				state_d            = hawk_pkg::idle;
			end
			// sticky until reset
			hawk_pkg::bus_error: begin
				state_d = hawk_pkg::bus_error;
			end
			default: begin
				state_d = hawk_pkg::idle;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q   <= hawk_pkg::idle;
			arvalid_q <= 1'b0;
			rready_q  <= 1'b0;
			trnsl_q   <= '0;
		end else begin
			state_q   <= state_d;
			arvalid_q <= arvalid_d;
			// reads are only issued when wanted so the data channel never stalls
			rready_q  <= 1'b1;
			trnsl_q   <= trnsl_d;
		end
	end

	always_ff @(posedge clk_i) begin
		hppa_q <= hppa_d;
		addr_q <= addr_d;
		line_q <= line_d;
	end

	assign result_pulse = trnsl_q.allow_access || trnsl_q.tbl_update ||
		trnsl_q.comp_pending || trnsl_q.no_free;

	assign rd_reqpkt.arvalid = arvalid_q;
	assign rd_reqpkt.addr    = addr_q;
	assign rd_reqpkt.rready  = rready_q;
	assign trnsl_reqpkt      = trnsl_q;
	assign lst_pop           = trnsl_q.tbl_update;
	assign bus_error         = (state_q == hawk_pkg::bus_error);
	// ready returns the cycle after the result pulse
	assign pgrd_mngr_ready   = (state_q == hawk_pkg::idle) && !result_pulse;

	a_rlast_with_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
		rd_resppkt.rvalid |-> rd_resppkt.rlast);

	a_hppa_above_base: assert property (@(posedge clk_i) disable iff (!rst_ni)
		lkup_reqpkt.lookup |-> (lkup_reqpkt.hppa >= `HAWK_HPPA_BASE));

endmodule

//--- logic/hawk_top.sv
// page-guard top: lookup FSM plus free-list pointers on one AXI read port
// the requester drives lookup and push strobes, memory answers the reads
`timescale 1ns/1ps

module hawk_top (
	input  logic                       clk_i,
	input  logic                       rst_ni,
	input  hawk_pkg::att_lkup_reqpkt_t lkup_reqpkt,
	input  logic                       free_push,
	input  hawk_pkg::axi_rd_rdypkt_t   rd_rdypkt,
	input  hawk_pkg::axi_rd_resppkt_t  rd_resppkt,
	output hawk_pkg::axi_rd_reqpkt_t   rd_reqpkt,
	output hawk_pkg::trnsl_reqpkt_t    trnsl_reqpkt,
	output logic                       pgrd_mngr_ready,
	output logic                       bus_error
);

	hawk_pkg::free_lst_ptrs_t lst_ptrs;
	logic                     lst_empty;
	// tbl_update strobe, advances head
	logic                     lst_pop;

	hawk_pgrd_mngr pgrd_mngr_i (
		.clk_i           (clk_i),
		.rst_ni          (rst_ni),
		.lkup_reqpkt     (lkup_reqpkt),
		.lst_ptrs        (lst_ptrs),
		.lst_empty       (lst_empty),
		.rd_rdypkt       (rd_rdypkt),
		.rd_resppkt      (rd_resppkt),
		.rd_reqpkt       (rd_reqpkt),
		.trnsl_reqpkt    (trnsl_reqpkt),
		.lst_pop         (lst_pop),
		.pgrd_mngr_ready (pgrd_mngr_ready),
		.bus_error       (bus_error)
	);

	hawk_free_lst_ptrs free_lst_ptrs_i (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.lst_pop   (lst_pop),
		.free_push (free_push),
		.lst_ptrs  (lst_ptrs),
		.lst_empty (lst_empty)
	);

endmodule

//--- sim/hawk_clk_gen.sv
// testbench clock and power-on reset for the page-guard testbench
// 8 ns period, reset held low for the first 8 rising edges
`timescale 1ns/1ps

module hawk_clk_gen (
	output logic clk_i,
	output logic rst_ni
);

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	initial begin
		rst_ni = 1'b0;
		repeat (8) @(posedge clk_i);
		rst_ni <= 1'b1;
	end

endmodule

//--- sim/hawk_tb.sv
// page-guard testbench with a model memory that answers att and free-list reads
// random lookups are checked against a reference built from the address rules
`timescale 1ns/1ps
`include "hawk_params.svh"

module hawk_tb;

	localparam int ATT_LINES = 8;
	localparam int LST_LINES = `HAWK_LST_ENTRY_MAX / 4;
	localparam int WAIT_MAX  = 200;

	logic clk_i;
	logic gen_rst_n;
	logic tb_rst_n = 1'b1;
	logic rst_ni;
	hawk_pkg::att_lkup_reqpkt_t lkup_reqpkt = '0;
	logic free_push = 1'b0;
	hawk_pkg::axi_rd_rdypkt_t  rd_rdypkt  = '0;
	hawk_pkg::axi_rd_resppkt_t rd_resppkt = '0;
	hawk_pkg::axi_rd_reqpkt_t  rd_reqpkt;
	hawk_pkg::trnsl_reqpkt_t   trnsl_reqpkt;
	logic pgrd_mngr_ready;
	logic bus_error;

	// model memory with one entry per 64-byte line
	logic [`HAWK_AXI_DATA_WIDTH-1:0] att_mem [ATT_LINES];
	logic [`HAWK_AXI_DATA_WIDTH-1:0] lst_mem [LST_LINES];
	logic [`HAWK_AXI_ADDR_WIDTH-1:0] exp_addr_q [$];
	int   head_m = 0;
	int   tail_m = 0;
	logic inject_err = 1'b0;
	logic err_mode = 1'b0;
	int   mismatch_cnt = 0;
	int   timeout_cnt = 0;
	int   resp_err_cnt = 0;
	// responder state
	logic rdy_last = 1'b0;
	logic pending = 1'b0;
	int   delay = 0;
	logic [`HAWK_AXI_ADDR_WIDTH-1:0] line_addr = '0;

	// second reset source for the bus error recovery
	assign rst_ni = gen_rst_n && tb_rst_n;

	hawk_clk_gen clk_gen_i (
		.clk_i  (clk_i),
		.rst_ni (gen_rst_n)
	);

	hawk_top hawk_top_i (
		.clk_i           (clk_i),
		.rst_ni          (rst_ni),
		.lkup_reqpkt     (lkup_reqpkt),
		.free_push       (free_push),
		.rd_rdypkt       (rd_rdypkt),
		.rd_resppkt      (rd_resppkt),
		.rd_reqpkt       (rd_reqpkt),
		.trnsl_reqpkt    (trnsl_reqpkt),
		.pgrd_mngr_ready (pgrd_mngr_ready),
		.bus_error       (bus_error)
	);

	// att line is base plus 64 bytes per group of 8 pages
	function automatic logic [`HAWK_AXI_ADDR_WIDTH-1:0] att_addr(
		input logic [`HAWK_AXI_ADDR_WIDTH-1:0] hppa
	);
		logic [`HAWK_AXI_ADDR_WIDTH-1:0] off;
		off = hppa - `HAWK_HPPA_BASE;
		return `HAWK_ATT_START + (off / 48'd8) * 48'd64;
	endfunction

	function automatic logic [`HAWK_AXI_ADDR_WIDTH-1:0] lst_addr(input int head);
		return `HAWK_LIST_START + 48'(head / 4) * 48'd64;
	endfunction

	// expected result from the model memory and model pointers
	function automatic hawk_pkg::trnsl_reqpkt_t ref_trnsl(
		input logic [`HAWK_AXI_ADDR_WIDTH-1:0] hppa,
		input int                              head,
		input int                              tail
	);
		hawk_pkg::trnsl_reqpkt_t exp;
		hawk_pkg::att_entry_t    ent;
		hawk_pkg::lst_entry_t    slot;
		int                      page;
		exp  = '0;
		page = int'(hppa - `HAWK_HPPA_BASE);
		ent  = att_mem[page / 8][(page % 8) * 64 +: 64];
		if (ent.valid && ent.sts == hawk_pkg::sts_uncomp) begin
			exp.allow_access = 1'b1;
			exp.att_hit      = 1'b1;
			exp.sts          = ent.sts;
			exp.ppa          = ent.ppa;
			exp.hppa         = hppa;
		end else if (ent.valid && ent.sts == hawk_pkg::sts_comp) begin
			exp.comp_pending = 1'b1;
			exp.att_hit      = 1'b1;
			exp.sts          = ent.sts;
			exp.ppa          = ent.ppa;
			exp.hppa         = hppa;
		end else if (ent.valid) begin
			// dalloc hit reports nothing
			exp = '0;
		end else if (head == tail) begin
			exp.no_free = 1'b1;
			exp.hppa    = hppa;
		end else begin
			slot           = lst_mem[head / 4][(head % 4) * 128 +: 128];
			exp.tbl_update = 1'b1;
			exp.sts        = hawk_pkg::sts_uncomp;
			exp.ppa        = slot.ppa;
			exp.hppa       = hppa;
		end
		return exp;
	endfunction

	function automatic logic [`HAWK_AXI_DATA_WIDTH-1:0] read_line(
		input logic [`HAWK_AXI_ADDR_WIDTH-1:0] addr
	);
		if (addr >= `HAWK_LIST_START) begin
			return lst_mem[int'((addr - `HAWK_LIST_START) / 48'd64) % LST_LINES];
		end
		return att_mem[int'((addr - `HAWK_ATT_START) / 48'd64) % ATT_LINES];
	endfunction

	task automatic set_att(input int line, input int slot, input logic valid,
		input hawk_pkg::att_sts_t sts);
		hawk_pkg::att_entry_t ent;
		ent       = att_mem[line][slot * 64 +: 64];
		ent.valid = valid;
		ent.sts   = sts;
		att_mem[line][slot * 64 +: 64] = ent;
	endtask

	task automatic fill_memory();
		hawk_pkg::att_entry_t ent;
		hawk_pkg::lst_entry_t slot;
		for (int l = 0; l < ATT_LINES; l++) begin
			for (int s = 0; s < 8; s++) begin
				ent.valid = 1'($urandom % 2);
				ent.sts   = hawk_pkg::att_sts_t'(2'($urandom % 3));
				ent.rsvd  = '0;
				ent.ppa   = {4'($urandom), $urandom};
				att_mem[l][s * 64 +: 64] = ent;
			end
		end
		for (int l = 0; l < LST_LINES; l++) begin
			for (int s = 0; s < 4; s++) begin
				slot.rsvd = '0;
				slot.ppa  = {4'($urandom), $urandom};
				lst_mem[l][s * 128 +: 128] = slot;
			end
		end
		// first four pages cover each decode branch
		set_att(0, 0, 1'b1, hawk_pkg::sts_uncomp);
		set_att(0, 1, 1'b1, hawk_pkg::sts_comp);
		set_att(0, 2, 1'b1, hawk_pkg::sts_dalloc);
		set_att(0, 3, 1'b0, hawk_pkg::sts_uncomp);
	endtask

	task automatic check_trnsl(input hawk_pkg::trnsl_reqpkt_t got,
		input hawk_pkg::trnsl_reqpkt_t exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("mismatch at %0t: trnsl_reqpkt got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic check_addr(input hawk_pkg::axi_rd_reqpkt_t got,
		input hawk_pkg::axi_rd_reqpkt_t exp);
		if (got !== exp) begin
			resp_err_cnt++;
			$display("mismatch at %0t: rd_reqpkt got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic wait_ready();
		int cnt;
		cnt = 0;
		@(negedge clk_i);
		while (!pgrd_mngr_ready && cnt < WAIT_MAX) begin
			@(negedge clk_i);
			cnt++;
		end
		if (!pgrd_mngr_ready) begin
			timeout_cnt++;
			$display("manager never became ready at %0t", $time);
		end
	endtask

	task automatic push_pages(input int n);
		repeat (n) begin
			@(posedge clk_i);
			free_push <= 1'b1;
			tail_m = (tail_m + 1) % `HAWK_LST_ENTRY_MAX;
		end
		@(posedge clk_i);
		free_push <= 1'b0;
	endtask

	// one lookup and then a wait for a strobe or for ready to come back
	task automatic run_lookup(input logic [`HAWK_AXI_ADDR_WIDTH-1:0] hppa);
		hawk_pkg::trnsl_reqpkt_t exp;
		int                      cnt;
		logic                    done;
		wait_ready();
		exp = ref_trnsl(hppa, head_m, tail_m);
		exp_addr_q.push_back(att_addr(hppa));
		if (exp.tbl_update) begin
			exp_addr_q.push_back(lst_addr(head_m));
		end
		@(posedge clk_i);
		lkup_reqpkt <= {1'b1, hppa};
		@(posedge clk_i);
		lkup_reqpkt <= '0;
		cnt  = 0;
		done = 1'b0;
		while (!done && cnt < WAIT_MAX) begin
			@(negedge clk_i);
			cnt++;
			done = trnsl_reqpkt.allow_access || trnsl_reqpkt.tbl_update ||
				trnsl_reqpkt.comp_pending || trnsl_reqpkt.no_free || pgrd_mngr_ready;
		end
		if (!done) begin
			timeout_cnt++;
			$display("lookup of page %h did not complete at %0t", hppa, $time);
		end else begin
			check_trnsl(trnsl_reqpkt, exp);
			if (exp.tbl_update) begin
				head_m = (head_m + 1) % `HAWK_LST_ENTRY_MAX;
			end
		end
	endtask

	// error response on an att read followed by ignored lookups and a reset
	task automatic run_error_case();
		int cnt;
		wait_ready();
		exp_addr_q.push_back(att_addr(`HAWK_HPPA_BASE));
		@(posedge clk_i);
		inject_err  <= 1'b1;
		lkup_reqpkt <= {1'b1, `HAWK_HPPA_BASE};
		@(posedge clk_i);
		lkup_reqpkt <= '0;
		cnt = 0;
		while (!bus_error && cnt < WAIT_MAX) begin
			@(negedge clk_i);
			cnt++;
		end
		if (!bus_error) begin
			timeout_cnt++;
			$display("bus_error never rose after the error response at %0t", $time);
		end
		err_mode = 1'b1;
		@(posedge clk_i);
		inject_err <= 1'b0;
		repeat (3) begin
			@(posedge clk_i);
			lkup_reqpkt <= {1'b1, `HAWK_HPPA_BASE + 48'd1};
			@(posedge clk_i);
			lkup_reqpkt <= '0;
			repeat (4) @(posedge clk_i);
		end
		@(negedge clk_i);
		check_flag("pgrd_mngr_ready", pgrd_mngr_ready, 1'b0);
		check_flag("bus_error", bus_error, 1'b1);
		@(posedge clk_i);
		tb_rst_n <= 1'b0;
		repeat (8) @(posedge clk_i);
		tb_rst_n <= 1'b1;
		err_mode = 1'b0;
		head_m   = 0;
		tail_m   = 0;
		exp_addr_q.delete();
		@(negedge clk_i);
		check_flag("bus_error", bus_error, 1'b0);
		check_flag("pgrd_mngr_ready", pgrd_mngr_ready, 1'b1);
	endtask

	// memory side with random arready and one beat back after 1 to 6 cycles
	always @(posedge clk_i) begin
		if (rd_reqpkt.arvalid) begin
			if (!rdy_last) begin
				resp_err_cnt++;
				$display("arvalid raised while arready was low at %0t", $time);
			end
			if (err_mode) begin
				resp_err_cnt++;
				$display("arvalid issued in the bus error state at %0t", $time);
			end else if (exp_addr_q.size() == 0) begin
				resp_err_cnt++;
				$display("arvalid issued with no read expected at %0t", $time);
			end else begin
				check_addr(rd_reqpkt, {1'b1, exp_addr_q.pop_front(), 1'b1});
			end
			line_addr = rd_reqpkt.addr;
			delay     = 1 + int'($urandom % 6);
			pending   = 1'b1;
		end
		// value the DUT saw at this edge
		rdy_last = rd_rdypkt.arready;
		rd_rdypkt.arready <= ($urandom % 4) != 0;
		rd_resppkt <= '0;
		if (pending) begin
			delay--;
			if (delay == 0) begin
				pending = 1'b0;
				rd_resppkt <= {1'b1, 1'b1, (inject_err ? 2'b10 : 2'b00), read_line(line_addr)};
			end
		end
	end

	initial begin
		int cnt;
		void'($urandom(8530));
		fill_memory();
		cnt = 0;
		while (rst_ni !== 1'b1 && cnt < WAIT_MAX) begin
			@(negedge clk_i);
			cnt++;
		end
		if (rst_ni !== 1'b1) begin
			timeout_cnt++;
			$display("reset was never released");
		end
		@(negedge clk_i);
		check_flag("pgrd_mngr_ready", pgrd_mngr_ready, 1'b1);
		check_flag("bus_error", bus_error, 1'b0);
		check_trnsl(trnsl_reqpkt, '0);
		// empty list miss followed by uncomp, comp and dalloc hits
		run_lookup(`HAWK_HPPA_BASE + 48'd3);
		run_lookup(`HAWK_HPPA_BASE + 48'd0);
		run_lookup(`HAWK_HPPA_BASE + 48'd1);
		run_lookup(`HAWK_HPPA_BASE + 48'd2);
		push_pages(20);
		run_lookup(`HAWK_HPPA_BASE + 48'd3);
		repeat (40) run_lookup(`HAWK_HPPA_BASE + 48'($urandom % 64));
		run_error_case();
		push_pages(4);
		run_lookup(`HAWK_HPPA_BASE + 48'd3);
		run_lookup(`HAWK_HPPA_BASE + 48'd0);
		repeat (10) @(posedge clk_i);
		$display("errors: %0d mismatches, %0d read channel, %0d timeouts",
			mismatch_cnt, resp_err_cnt, timeout_cnt);
		if (mismatch_cnt + resp_err_cnt + timeout_cnt == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- hawk_top.f
+incdir+logic
logic/hawk_pkg.sv
logic/hawk_free_lst_ptrs.sv
logic/hawk_pgrd_mngr.sv
logic/hawk_top.sv
sim/hawk_clk_gen.sv
sim/hawk_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the page-guard testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f hawk_top.f --top-module hawk_tb \
	-o hawk_sim > build.log 2>&1 &&
./obj_dir/hawk_sim > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "test failed" sim.log &&
{ echo "simulation reported failure, see sim.log"; exit 1; } ||
{ echo "simulation finished without failure"; exit 0; }
